/* verilog/pcie_link_pkg.sv */
package pcie_link_pkg;

  // ----------------------------------------
  // link side of the user datapath
  // ----------------------------------------

  // one TLP word per PIPE_PCLK_IN cycle on the core side
  localparam int PHY_DATA_W = 32;

  // byte enables per TLP word
  localparam int PHY_KEEP_W = PHY_DATA_W / 8;

  // user sideband width, same on both sides of the converters
  localparam int TLP_USER_W = 5;

  // carried unchanged on every word and beat
  typedef logic [TLP_USER_W-1:0] tlp_user_t;

endpackage

/* verilog/pcie_app_pkg.sv */
package pcie_app_pkg;

  // ----------------------------------------
  // application side of the user datapath
  // ----------------------------------------

  // application stream beat, two TLP words wide
  localparam int APP_DATA_W = 64;

  // byte enables per application beat
  localparam int APP_KEEP_W = APP_DATA_W / 8;

endpackage

/* verilog/axis_stream_if.sv */
interface axis_stream_if
  import pcie_link_pkg::*;
#(
  parameter int DATA_W = 32
);

  localparam int KEEP_W = DATA_W / 8;

  logic [DATA_W-1:0] tdata;
  logic [KEEP_W-1:0] tkeep;
  tlp_user_t         tuser;
  logic              tlast;
  logic              tvalid;
  logic              tready;

  // payload and tvalid stay stable from tvalid high until the transfer
  modport sender (
    output tdata,
    output tkeep,
    output tuser,
    output tlast,
    output tvalid,
    input  tready
  );

  modport receiver (
    input  tdata,
    input  tkeep,
    input  tuser,
    input  tlast,
    input  tvalid,
    output tready
  );

endinterface

/* verilog/link_reset_sync.sv */
module link_reset_sync (
  input  logic PIPE_PCLK_IN,
  input  logic clock_locked,
  input  logic phystatus_rst_i,
  input  logic trn_lnk_up_i,
  output logic phy_rdy_n_o,
  output logic user_lnk_up_o,
  output logic user_reset_o
);

  logic lock_q;
  logic user_reset_q;

  // pll lock, dropped at once when the lock goes away
  always_ff @(posedge PIPE_PCLK_IN or negedge clock_locked) begin
    if (!clock_locked) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= 1'b1;
    end
  end

  // phy status reset only passes once the lock is registered
  always_ff @(posedge PIPE_PCLK_IN or negedge clock_locked) begin
    if (!clock_locked) begin
      phy_rdy_n_o <= 1'b0;
    end else if (!lock_q) begin
      phy_rdy_n_o <= 1'b0;
    end else begin
      phy_rdy_n_o <= phystatus_rst_i;
    end
  end

  // ----------------------------------------
  // user side status
  // ----------------------------------------

  // two flops, so user reset falls on the 2nd edge after lock
  always_ff @(posedge PIPE_PCLK_IN or negedge clock_locked) begin
    if (!clock_locked) begin
      user_lnk_up_o <= 1'b0;
      user_reset_q  <= 1'b1;
      user_reset_o  <= 1'b1;
    end else begin
      user_lnk_up_o <= trn_lnk_up_i;
      user_reset_q  <= 1'b0;
      user_reset_o  <= user_reset_q;
    end
  end

endmodule

/* verilog/axis_width_down.sv */
module axis_width_down
  import pcie_link_pkg::*;
#(
  parameter int IN_W  = 64,
  parameter int OUT_W = 32
) (
  input  logic             PIPE_PCLK_IN,
  input  logic             user_reset_i,
  input  logic             lnk_up_i,
  axis_stream_if.receiver  s,
  axis_stream_if.sender    m
);

  // IN_W is a power-of-two multiple of OUT_W
  localparam int RATIO  = IN_W / OUT_W;
  localparam int IN_KW  = IN_W / 8;
  localparam int OUT_KW = OUT_W / 8;
  localparam int IDX_W  = (RATIO > 1) ? $clog2(RATIO) : 1;

  // held wide beat
  logic [IN_W-1:0]  data_q;
  logic [IN_KW-1:0] keep_q;
  tlp_user_t        user_q;
  logic             last_q;

  // word currently on the output
  logic [IDX_W-1:0] idx_q;
  logic             valid_q;

  logic [IDX_W-1:0] next_idx;
  logic             has_next;
  logic             s_fire;
  logic             m_fire;

  // ----------------------------------------
  // next word to send
  // ----------------------------------------

  // lowest upper word with any keep bit set, empty words are skipped
  always_comb begin
    has_next = 1'b0;
    next_idx = idx_q;
    for (int j = RATIO - 1; j > 0; j--) begin
      if ((j > idx_q) && (|keep_q[j*OUT_KW +: OUT_KW])) begin
        has_next = 1'b1;
        next_idx = IDX_W'(j);
      end
    end
  end

  assign m_fire = valid_q && m.tready;
  assign s_fire = s.tvalid && s.tready;

  // a new beat is taken as the last word of the held one leaves
  assign s.tready = !user_reset_i && lnk_up_i &&
                    (!valid_q || (m.tready && !has_next));

  // ----------------------------------------
  // beat register
  // ----------------------------------------

  always_ff @(posedge PIPE_PCLK_IN) begin
    if (s_fire) begin
      data_q <= s.tdata;
      keep_q <= s.tkeep;
      user_q <= s.tuser;
      last_q <= s.tlast;
    end
  end

  always_ff @(posedge PIPE_PCLK_IN or posedge user_reset_i) begin
    if (user_reset_i) begin
      valid_q <= 1'b0;
      idx_q   <= '0;
    end else if (s_fire) begin
      // lowest word goes out first, always
      valid_q <= 1'b1;
      idx_q   <= '0;
    end else if (m_fire) begin
      if (has_next) begin
        idx_q <= next_idx;
      end else begin
        valid_q <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // output word
  // ----------------------------------------

  assign m.tdata  = data_q[idx_q*OUT_W +: OUT_W];
  assign m.tkeep  = keep_q[idx_q*OUT_KW +: OUT_KW];
  assign m.tuser  = user_q;
  // tlast only on the final word that is actually sent
  assign m.tlast  = last_q && !has_next;
  assign m.tvalid = valid_q;

endmodule

/* verilog/axis_width_up.sv */
module axis_width_up
  import pcie_link_pkg::*;
#(
  parameter int IN_W  = 32,
  parameter int OUT_W = 64
) (
  input  logic             PIPE_PCLK_IN,
  input  logic             user_reset_i,
  axis_stream_if.receiver  s,
  axis_stream_if.sender    m
);

  localparam int RATIO  = OUT_W / IN_W;
  localparam int IN_KW  = IN_W / 8;
  localparam int OUT_KW = OUT_W / 8;
  localparam int IDX_W  = (RATIO > 1) ? $clog2(RATIO) : 1;

  // wide beat being filled, or waiting on the output
  logic [OUT_W-1:0]  data_q;
  logic [OUT_KW-1:0] keep_q;
  tlp_user_t         user_q;
  logic              last_q;

  // next lane to fill
  logic [IDX_W-1:0]  idx_q;
  logic              valid_q;

  logic [OUT_W-1:0]  data_d;
  logic [OUT_KW-1:0] keep_d;
  logic              close;
  logic              s_fire;
  logic              m_fire;

  assign m_fire = valid_q && m.tready;
  assign s_fire = s.tvalid && s.tready;

  // stall input while a completed beat has not been taken
  assign s.tready = !user_reset_i && (!valid_q || m.tready);

  // beat ends when full or on tlast
  assign close = s.tlast || (idx_q == IDX_W'(RATIO - 1));

  // ----------------------------------------
  // lane merge
  // ----------------------------------------

  // first word of a beat clears the lanes, so unfilled lanes read zero
  always_comb begin
    data_d = (idx_q == '0) ? '0 : data_q;
    keep_d = (idx_q == '0) ? '0 : keep_q;
    data_d[idx_q*IN_W +: IN_W]   = s.tdata;
    keep_d[idx_q*IN_KW +: IN_KW] = s.tkeep;
  end

  always_ff @(posedge PIPE_PCLK_IN) begin
    if (s_fire) begin
      data_q <= data_d;
      keep_q <= keep_d;
      // tuser of the final word wins
      user_q <= s.tuser;
      last_q <= s.tlast;
    end
  end

  // ----------------------------------------
  // control
  // ----------------------------------------

  always_ff @(posedge PIPE_PCLK_IN or posedge user_reset_i) begin
    if (user_reset_i) begin
      valid_q <= 1'b0;
      idx_q   <= '0;
    end else begin
      if (m_fire) begin
        valid_q <= 1'b0;
      end
      if (s_fire) begin
        if (close) begin
          valid_q <= 1'b1;
          idx_q   <= '0;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

  assign m.tdata  = data_q;
  assign m.tkeep  = keep_q;
  assign m.tuser  = user_q;
  assign m.tlast  = last_q;
  assign m.tvalid = valid_q;

endmodule

/* verilog/pcie_stream_top.sv */
module pcie_stream_top
  import pcie_link_pkg::*;
  import pcie_app_pkg::*;
(
  input  logic                  PIPE_PCLK_IN,
  input  logic                  clock_locked,
  input  logic                  phystatus_rst_i,
  input  logic                  trn_lnk_up_i,

  // application transmit
  input  logic [APP_DATA_W-1:0] s_app_tdata_i,
  input  logic [APP_KEEP_W-1:0] s_app_tkeep_i,
  input  tlp_user_t             s_app_tuser_i,
  input  logic                  s_app_tlast_i,
  input  logic                  s_app_tvalid_i,
  output logic                  s_app_tready_o,

  // TLP transmit
  output logic [PHY_DATA_W-1:0] m_tlp_tdata_o,
  output logic [PHY_KEEP_W-1:0] m_tlp_tkeep_o,
  output tlp_user_t             m_tlp_tuser_o,
  output logic                  m_tlp_tlast_o,
  output logic                  m_tlp_tvalid_o,
  input  logic                  m_tlp_tready_i,

  // TLP receive
  input  logic [PHY_DATA_W-1:0] s_tlp_tdata_i,
  input  logic [PHY_KEEP_W-1:0] s_tlp_tkeep_i,
  input  tlp_user_t             s_tlp_tuser_i,
  input  logic                  s_tlp_tlast_i,
  input  logic                  s_tlp_tvalid_i,
  output logic                  s_tlp_tready_o,

  // application receive
  output logic [APP_DATA_W-1:0] m_app_tdata_o,
  output logic [APP_KEEP_W-1:0] m_app_tkeep_o,
  output tlp_user_t             m_app_tuser_o,
  output logic                  m_app_tlast_o,
  output logic                  m_app_tvalid_o,
  input  logic                  m_app_tready_i,

  // status
  output logic                  phy_rdy_n_o,
  output logic                  user_lnk_up_o
);

  logic user_reset;

  axis_stream_if #(.DATA_W(APP_DATA_W)) app_tx ();
  axis_stream_if #(.DATA_W(PHY_DATA_W)) tlp_tx ();
  axis_stream_if #(.DATA_W(PHY_DATA_W)) tlp_rx ();
  axis_stream_if #(.DATA_W(APP_DATA_W)) app_rx ();

  link_reset_sync i_link_reset_sync (
    .PIPE_PCLK_IN    (PIPE_PCLK_IN),
    .clock_locked    (clock_locked),
    .phystatus_rst_i (phystatus_rst_i),
    .trn_lnk_up_i    (trn_lnk_up_i),
    .phy_rdy_n_o     (phy_rdy_n_o),
    .user_lnk_up_o   (user_lnk_up_o),
    .user_reset_o    (user_reset)
  );

  // ----------------------------------------
  // transmit, 64 bit beats to 32 bit words
  // ----------------------------------------

  assign app_tx.tdata   = s_app_tdata_i;
  assign app_tx.tkeep   = s_app_tkeep_i;
  assign app_tx.tuser   = s_app_tuser_i;
  assign app_tx.tlast   = s_app_tlast_i;
  assign app_tx.tvalid  = s_app_tvalid_i;
  assign s_app_tready_o = app_tx.tready;

  axis_width_down #(
    .IN_W  (APP_DATA_W),
    .OUT_W (PHY_DATA_W)
  ) i_axis_width_down (
    .PIPE_PCLK_IN (PIPE_PCLK_IN),
    .user_reset_i (user_reset),
    .lnk_up_i     (user_lnk_up_o),
    .s            (app_tx),
    .m            (tlp_tx)
  );

  assign m_tlp_tdata_o  = tlp_tx.tdata;
  assign m_tlp_tkeep_o  = tlp_tx.tkeep;
  assign m_tlp_tuser_o  = tlp_tx.tuser;
  assign m_tlp_tlast_o  = tlp_tx.tlast;
  assign m_tlp_tvalid_o = tlp_tx.tvalid;
  assign tlp_tx.tready  = m_tlp_tready_i;

  // ----------------------------------------
  // receive, 32 bit words to 64 bit beats
  // ----------------------------------------

  assign tlp_rx.tdata   = s_tlp_tdata_i;
  assign tlp_rx.tkeep   = s_tlp_tkeep_i;
  assign tlp_rx.tuser   = s_tlp_tuser_i;
  assign tlp_rx.tlast   = s_tlp_tlast_i;
  assign tlp_rx.tvalid  = s_tlp_tvalid_i;
  assign s_tlp_tready_o = tlp_rx.tready;

  axis_width_up #(
    .IN_W  (PHY_DATA_W),
    .OUT_W (APP_DATA_W)
  ) i_axis_width_up (
    .PIPE_PCLK_IN (PIPE_PCLK_IN),
    .user_reset_i (user_reset),
    .s            (tlp_rx),
    .m            (app_rx)
  );

  assign m_app_tdata_o  = app_rx.tdata;
  assign m_app_tkeep_o  = app_rx.tkeep;
  assign m_app_tuser_o  = app_rx.tuser;
  assign m_app_tlast_o  = app_rx.tlast;
  assign m_app_tvalid_o = app_rx.tvalid;
  assign app_rx.tready  = m_app_tready_i;

endmodule

/* test/tb_pcie_stream.sv */
module tb_pcie_stream
  import pcie_link_pkg::*;
  import pcie_app_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_PERIOD = 20;
  localparam logic [15:0] LFSR_TAPS  = 16'hB400;
  localparam int          N_BEATS    = 8;
  localparam int          N_PKTS     = 6;
  localparam int          PKT_LEN [N_PKTS] = '{2, 1, 4, 3, 1, 2};
  localparam int          RX_WORDS   = 13;

  // rough cycle count of each test
  localparam int T_RESET = 12;
  localparam int T_GATE  = 12;
  localparam int T_SPLIT = 2 * N_BEATS + 6;
  localparam int T_SHORT = 14;
  localparam int T_PACK  = RX_WORDS + 8;
  localparam int T_BP    = 3 * (2 * N_BEATS + RX_WORDS) + 8;
  localparam int WATCHDOG_NS =
    (T_RESET + T_GATE + T_SPLIT + T_SHORT + T_PACK + T_BP) * 4 * CLK_PERIOD;

  typedef struct packed {
    logic [PHY_DATA_W-1:0] data;
    logic [PHY_KEEP_W-1:0] keep;
    tlp_user_t             user;
    logic                  last;
  } tlp_word_t;

  typedef struct packed {
    logic [APP_DATA_W-1:0] data;
    logic [APP_KEEP_W-1:0] keep;
    tlp_user_t             user;
    logic                  last;
  } app_beat_t;

  logic                  PIPE_PCLK_IN;
  logic                  clock_locked;
  logic                  phystatus_rst_i;
  logic                  trn_lnk_up_i;
  logic [APP_DATA_W-1:0] s_app_tdata_i;
  logic [APP_KEEP_W-1:0] s_app_tkeep_i;
  tlp_user_t             s_app_tuser_i;
  logic                  s_app_tlast_i;
  logic                  s_app_tvalid_i;
  logic                  s_app_tready_o;
  logic [PHY_DATA_W-1:0] m_tlp_tdata_o;
  logic [PHY_KEEP_W-1:0] m_tlp_tkeep_o;
  tlp_user_t             m_tlp_tuser_o;
  logic                  m_tlp_tlast_o;
  logic                  m_tlp_tvalid_o;
  logic                  m_tlp_tready_i;
  logic [PHY_DATA_W-1:0] s_tlp_tdata_i;
  logic [PHY_KEEP_W-1:0] s_tlp_tkeep_i;
  tlp_user_t             s_tlp_tuser_i;
  logic                  s_tlp_tlast_i;
  logic                  s_tlp_tvalid_i;
  logic                  s_tlp_tready_o;
  logic [APP_DATA_W-1:0] m_app_tdata_o;
  logic [APP_KEEP_W-1:0] m_app_tkeep_o;
  tlp_user_t             m_app_tuser_o;
  logic                  m_app_tlast_o;
  logic                  m_app_tvalid_o;
  logic                  m_app_tready_i;
  logic                  phy_rdy_n_o;
  logic                  user_lnk_up_o;

  logic [15:0] lfsr_q = 16'd15;
  int          err_cnt = 0;

  // stimulus still to be accepted, and outputs still to be seen
  app_beat_t app_in_q [$];
  tlp_word_t tlp_in_q [$];
  tlp_word_t tlp_exp_q [$];
  app_beat_t app_exp_q [$];
  // stimulus of the split and pack tests, replayed under back-pressure
  app_beat_t tx_saved_q [$];
  tlp_word_t rx_saved_q [$];

  // half of a beat waiting for its upper word
  tlp_word_t pend;
  logic      pend_valid = 1'b0;

  pcie_stream_top i_pcie_stream_top (.*);

  initial PIPE_PCLK_IN = 1'b0;
  always #(CLK_PERIOD / 2) PIPE_PCLK_IN = ~PIPE_PCLK_IN;

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired, the DUT stopped moving data before the tests ended");
  end

  // galois lfsr, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic next_cycle();
    @(posedge PIPE_PCLK_IN);
    #2;
  endtask

  // ----------------------------------------
  // checks
  // ----------------------------------------

  task automatic abort_run(input string why);
    err_cnt++;
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [PHY_DATA_W-1:0] got, exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0d ns %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_beat(input string name, input logic [APP_DATA_W-1:0] got, exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0d ns %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_user(input string name, input tlp_user_t got, exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0d ns %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_tlp_keep(input string name, input logic [PHY_KEEP_W-1:0] got, exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0d ns %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_keep(input string name, input logic [APP_KEEP_W-1:0] got, exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0d ns %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0d ns %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // ----------------------------------------
  // expected outputs
  // ----------------------------------------

  // low word first, upper word only when it has a byte enabled
  function automatic void expect_split(input app_beat_t b);
    tlp_word_t w;
    logic      hi;
    hi     = |b.keep[APP_KEEP_W-1:PHY_KEEP_W];
    w.data = b.data[PHY_DATA_W-1:0];
    w.keep = b.keep[PHY_KEEP_W-1:0];
    w.user = b.user;
    w.last = b.last && !hi;
    tlp_exp_q.push_back(w);
    if (hi) begin
      w.data = b.data[APP_DATA_W-1:PHY_DATA_W];
      w.keep = b.keep[APP_KEEP_W-1:PHY_KEEP_W];
      w.last = b.last;
      tlp_exp_q.push_back(w);
    end
  endfunction

  function automatic void expect_pack(input tlp_word_t w);
    app_beat_t b;
    if (!pend_valid && !w.last) begin
      pend       = w;
      pend_valid = 1'b1;
    end else begin
      if (pend_valid) begin
        b.data = {w.data, pend.data};
        b.keep = {w.keep, pend.keep};
      end else begin
        // lone last word, upper lane empty
        b.data = {{PHY_DATA_W{1'b0}}, w.data};
        b.keep = {{PHY_KEEP_W{1'b0}}, w.keep};
      end
      b.user     = w.user;
      b.last     = w.last;
      pend_valid = 1'b0;
      app_exp_q.push_back(b);
    end
  endfunction

  task automatic check_tlp_out();
    tlp_word_t e;
    if (tlp_exp_q.size() == 0) begin
      abort_run("a TLP word came out of the DUT when none was expected");
    end
    e = tlp_exp_q.pop_front();
    check_word("m_tlp_tdata_o", m_tlp_tdata_o, e.data);
    check_tlp_keep("m_tlp_tkeep_o", m_tlp_tkeep_o, e.keep);
    check_user("m_tlp_tuser_o", m_tlp_tuser_o, e.user);
    check_flag("m_tlp_tlast_o", m_tlp_tlast_o, e.last);
  endtask

  task automatic check_app_out();
    app_beat_t e;
    if (app_exp_q.size() == 0) begin
      abort_run("an application beat came out of the DUT when none was expected");
    end
    e = app_exp_q.pop_front();
    check_beat("m_app_tdata_o", m_app_tdata_o, e.data);
    check_keep("m_app_tkeep_o", m_app_tkeep_o, e.keep);
    check_user("m_app_tuser_o", m_app_tuser_o, e.user);
    check_flag("m_app_tlast_o", m_app_tlast_o, e.last);
  endtask

  // ----------------------------------------
  // stream driver and monitor
  // ----------------------------------------

  // both directions at once, until every queue is empty
  task automatic run_streams(input bit stall);
    int hold_tx;
    int hold_rx;
    hold_tx = 0;
    hold_rx = 0;
    while (app_in_q.size() + tlp_in_q.size() + tlp_exp_q.size() + app_exp_q.size() > 0) begin
      s_app_tvalid_i = (app_in_q.size() > 0);
      if (app_in_q.size() > 0) begin
        {s_app_tdata_i, s_app_tkeep_i, s_app_tuser_i, s_app_tlast_i} = app_in_q[0];
      end
      s_tlp_tvalid_i = (tlp_in_q.size() > 0);
      if (tlp_in_q.size() > 0) begin
        {s_tlp_tdata_i, s_tlp_tkeep_i, s_tlp_tuser_i, s_tlp_tlast_i} = tlp_in_q[0];
      end
      if (stall) begin
        // ready level held for 1 to 4 cycles
        if (hold_tx == 0) begin
          m_tlp_tready_i = 1'(rand_bits(1));
          hold_tx        = int'(rand_bits(2)) + 1;
        end
        if (hold_rx == 0) begin
          m_app_tready_i = 1'(rand_bits(1));
          hold_rx        = int'(rand_bits(2)) + 1;
        end
        hold_tx--;
        hold_rx--;
      end else begin
        m_tlp_tready_i = 1'b1;
        m_app_tready_i = 1'b1;
      end
      @(negedge PIPE_PCLK_IN);
      if (s_app_tvalid_i && s_app_tready_o) begin
        void'(app_in_q.pop_front());
      end
      if (s_tlp_tvalid_i && s_tlp_tready_o) begin
        void'(tlp_in_q.pop_front());
      end
      if (m_tlp_tvalid_o && m_tlp_tready_i) begin
        check_tlp_out();
      end
      if (m_app_tvalid_o && m_app_tready_i) begin
        check_app_out();
      end
      next_cycle();
    end
    s_app_tvalid_i = 1'b0;
    s_tlp_tvalid_i = 1'b0;
    m_tlp_tready_i = 1'b1;
    m_app_tready_i = 1'b1;
    // nothing left over or repeated
    @(negedge PIPE_PCLK_IN);
    check_flag("m_tlp_tvalid_o", m_tlp_tvalid_o, 1'b0);
    check_flag("m_app_tvalid_o", m_app_tvalid_o, 1'b0);
    next_cycle();
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------

  task automatic test_reset_status();
    repeat (3) next_cycle();
    @(negedge PIPE_PCLK_IN);
    check_flag("m_tlp_tvalid_o", m_tlp_tvalid_o, 1'b0);
    check_flag("m_app_tvalid_o", m_app_tvalid_o, 1'b0);
    check_flag("phy_rdy_n_o", phy_rdy_n_o, 1'b0);
    check_flag("user_lnk_up_o", user_lnk_up_o, 1'b0);
    next_cycle();
    trn_lnk_up_i    = 1'b1;
    phystatus_rst_i = 1'b1;
    @(negedge PIPE_PCLK_IN);
    check_flag("user_lnk_up_o", user_lnk_up_o, 1'b0);
    check_flag("phy_rdy_n_o", phy_rdy_n_o, 1'b0);
    next_cycle();
    // inputs fall apart so each output tracks its own
    trn_lnk_up_i = 1'b0;
    @(negedge PIPE_PCLK_IN);
    check_flag("user_lnk_up_o", user_lnk_up_o, 1'b1);
    check_flag("phy_rdy_n_o", phy_rdy_n_o, 1'b1);
    next_cycle();
    phystatus_rst_i = 1'b0;
    @(negedge PIPE_PCLK_IN);
    check_flag("user_lnk_up_o", user_lnk_up_o, 1'b0);
    check_flag("phy_rdy_n_o", phy_rdy_n_o, 1'b1);
    next_cycle();
    @(negedge PIPE_PCLK_IN);
    check_flag("user_lnk_up_o", user_lnk_up_o, 1'b0);
    check_flag("phy_rdy_n_o", phy_rdy_n_o, 1'b0);
    next_cycle();
  endtask

  task automatic test_link_gating();
    s_app_tdata_i  = APP_DATA_W'(rand_bits(APP_DATA_W));
    s_app_tkeep_i  = '1;
    s_app_tvalid_i = 1'b1;
    m_tlp_tready_i = 1'b1;
    repeat (8) begin
      @(negedge PIPE_PCLK_IN);
      check_flag("s_app_tready_o", s_app_tready_o, 1'b0);
      check_flag("m_tlp_tvalid_o", m_tlp_tvalid_o, 1'b0);
      next_cycle();
    end
    s_app_tvalid_i = 1'b0;
    trn_lnk_up_i   = 1'b1;
    next_cycle();
    @(negedge PIPE_PCLK_IN);
    check_flag("s_app_tready_o", s_app_tready_o, 1'b1);
    next_cycle();
  endtask

  task automatic test_tx_split();
    app_beat_t b;
    for (int i = 0; i < N_BEATS; i++) begin
      b.data = APP_DATA_W'(rand_bits(APP_DATA_W));
      b.keep = '1;
      b.user = tlp_user_t'(rand_bits(TLP_USER_W));
      b.last = 1'(rand_bits(1));
      app_in_q.push_back(b);
      tx_saved_q.push_back(b);
      expect_split(b);
    end
    run_streams(1'b0);
  endtask

  // odd beats are last with the upper word empty
  task automatic test_tx_short();
    app_beat_t b;
    for (int i = 0; i < 4; i++) begin
      b.data = APP_DATA_W'(rand_bits(APP_DATA_W));
      b.keep = (i % 2 == 1) ? 8'h0F : 8'hFF;
      b.user = tlp_user_t'(rand_bits(TLP_USER_W));
      b.last = (i % 2 == 1);
      app_in_q.push_back(b);
      expect_split(b);
    end
    run_streams(1'b0);
  endtask

  task automatic test_rx_pack();
    tlp_word_t w;
    for (int p = 0; p < N_PKTS; p++) begin
      for (int k = 0; k < PKT_LEN[p]; k++) begin
        w.data = PHY_DATA_W'(rand_bits(PHY_DATA_W));
        w.keep = '1;
        w.user = tlp_user_t'(rand_bits(TLP_USER_W));
        w.last = (k == PKT_LEN[p] - 1);
        tlp_in_q.push_back(w);
        rx_saved_q.push_back(w);
        expect_pack(w);
      end
    end
    run_streams(1'b0);
  endtask

  task automatic test_back_pressure();
    foreach (tx_saved_q[i]) begin
      app_in_q.push_back(tx_saved_q[i]);
      expect_split(tx_saved_q[i]);
    end
    foreach (rx_saved_q[i]) begin
      tlp_in_q.push_back(rx_saved_q[i]);
      expect_pack(rx_saved_q[i]);
    end
    run_streams(1'b1);
  endtask

  initial begin
    clock_locked    = 1'b0;
    phystatus_rst_i = 1'b0;
    trn_lnk_up_i    = 1'b0;
    s_app_tdata_i   = '0;
    s_app_tkeep_i   = '0;
    s_app_tuser_i   = '0;
    s_app_tlast_i   = 1'b0;
    s_app_tvalid_i  = 1'b0;
    m_tlp_tready_i  = 1'b0;
    s_tlp_tdata_i   = '0;
    s_tlp_tkeep_i   = '0;
    s_tlp_tuser_i   = '0;
    s_tlp_tlast_i   = 1'b0;
    s_tlp_tvalid_i  = 1'b0;
    m_app_tready_i  = 1'b0;
    repeat (3) @(posedge PIPE_PCLK_IN);
    #2;
    clock_locked = 1'b1;
    test_reset_status();
    test_link_gating();
    test_tx_split();
    test_tx_short();
    test_rx_pack();
    test_back_pressure();
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* files.f */
verilog/pcie_link_pkg.sv
verilog/pcie_app_pkg.sv
verilog/axis_stream_if.sv
verilog/link_reset_sync.sv
verilog/axis_width_down.sv
verilog/axis_width_up.sv
verilog/pcie_stream_top.sv
test/tb_pcie_stream.sv
